// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

	// ************************************************************************
	// widths
	// ************************************************************************

	localparam int ADDR_W = 64;     // rv64 pc
	localparam int INST_W = 32;     // no compressed insts
	localparam int WORD_W = 64;     // memory word, two insts
	localparam int IDX_W  = 8;      // word index width

	typedef logic [ADDR_W-1:0] addr_t;      // pc or branch target
	typedef logic [INST_W-1:0] inst_t;      // one instruction
	typedef logic [WORD_W-1:0] mem_word_t;  // one memory row
	typedef logic [IDX_W-1:0]  mem_idx_t;   // memory row number
	typedef logic [6:0]        opcode_t;    // inst[6:0]
	typedef logic [2:0]        funct3_t;    // inst[14:12]

	// ************************************************************************
	// reset pc and memory geometry
	// ************************************************************************

	localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;  // boot address

	localparam int MEM_WORDS = 256;  // 2 KiB of program
	localparam int IDX_LSB   = 3;    // pc[10:3] picks the row, pc[2] the half

	// ************************************************************************
	// risc-v encodings used by the flow classifier
	// ************************************************************************

	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;  // beq..bgeu

	// exact system encodings, all other fields zero
	localparam inst_t INST_ECALL = 32'h0000_0073;
	localparam inst_t INST_MRET  = 32'h3020_0073;

	// funct3 values of the branch group
	localparam funct3_t F3_BEQ  = 3'b000;  // also jalr's only legal funct3
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

endpackage

// ==== hdl/fetch_pc.sv ====
`timescale 1ns/1ps

// program counter of the fetch unit
// priority: redirect target, then hold, then pc + 4
module fetch_pc (
	input  logic              clk,
	input  logic              rst,
	input  fetch_pkg::addr_t  dnpc,     // resolved target from execute
	input  logic              pc_hold,  // keep current pc
	input  logic              pc_take,  // load dnpc
	output fetch_pkg::addr_t  pc
);

	fetch_pkg::addr_t pc_next;
	fetch_pkg::addr_t pc_seq;    // sequential successor

	// ************************************************************************
	// next pc selection
	// ************************************************************************

	assign pc_seq = pc + fetch_pkg::addr_t'(4);  // one 32-bit inst ahead

	always_comb begin
		if (pc_take) begin
			pc_next = dnpc;          // end of a control-flow wait
		end else if (pc_hold) begin
			pc_next = pc;            // back-pressure or waiting for target
		end else begin
			pc_next = pc_seq;
		end
	end

	// ************************************************************************
	// pc register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= fetch_pkg::RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// the low bits only stay clear if execute hands back aligned targets,
	// so this also guards the dnpc source
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (rst)
		pc[1:0] == 2'b00
	) else $error("fetch_pc: misaligned pc %h", pc);

endmodule

// ==== hdl/inst_mem.sv ====
`timescale 1ns/1ps

// on-chip program memory, 64 bits per row
// async read by pc, sync write from the fill port
module inst_mem (
	input  logic                  clk,
	input  fetch_pkg::addr_t      pc,         // fetch address
	input  logic                  load_en,    // write strobe for the fill port
	input  fetch_pkg::mem_idx_t   load_addr,  // row to write
	input  fetch_pkg::mem_word_t  load_data,  // two insts per row
	output fetch_pkg::inst_t      inst
);

	fetch_pkg::mem_word_t mem [fetch_pkg::MEM_WORDS];

	fetch_pkg::mem_idx_t  rd_idx;   // row picked by the pc
	fetch_pkg::mem_word_t rd_word;  // whole row before half select

	// ************************************************************************
	// fill port
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;  // visible to reads next cycle
		end
	end

	// ************************************************************************
	// read path, zero latency
	// ************************************************************************

	// high pc bits are dropped, out-of-range fetches wrap onto the array
	assign rd_idx  = pc[fetch_pkg::IDX_LSB +: fetch_pkg::IDX_W];
	assign rd_word = mem[rd_idx];

	// pc[2] set means the second inst of the row
	assign inst = pc[2] ? rd_word[63:32] : rd_word[31:0];

	// an X strobe would corrupt an unknown row of the program
	a_load_en_known: assert property (
		@(posedge clk) !$isunknown(load_en)
	) else $error("inst_mem: load_en is unknown");

endmodule

// ==== hdl/flow_decode.sv ====
`timescale 1ns/1ps

// flags insts that change control flow
// any of these stalls fetch until execute resolves the target
module flow_decode (
	input  fetch_pkg::inst_t  inst,
	output logic              redirect
);

	fetch_pkg::opcode_t opcode;
	fetch_pkg::funct3_t funct3;

	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_system;   // ecall or mret

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];

	// ************************************************************************
	// per-kind matches
	// ************************************************************************

	assign is_jal  = (opcode == fetch_pkg::OP_JAL);   // opcode alone decides
	assign is_jalr = (opcode == fetch_pkg::OP_JALR) && (funct3 == fetch_pkg::F3_BEQ);

	// branch opcode with funct3 010/011 is reserved, not a branch
	always_comb begin
		is_branch = 1'b0;
		if (opcode == fetch_pkg::OP_BRANCH) begin
			case (funct3)
				fetch_pkg::F3_BEQ,
				fetch_pkg::F3_BNE,
				fetch_pkg::F3_BLT,
				fetch_pkg::F3_BGE,
				fetch_pkg::F3_BLTU,
				fetch_pkg::F3_BGEU: is_branch = 1'b1;
				default:            is_branch = 1'b0;
			endcase
		end
	end

	// whole-word compare, a single flipped bit is not a trap
	assign is_system = (inst == fetch_pkg::INST_ECALL) ||
	                   (inst == fetch_pkg::INST_MRET);

	// ************************************************************************
	// combined flag
	// ************************************************************************

	assign redirect = is_jal | is_jalr | is_branch | is_system;

endmodule

// ==== hdl/fetch_ctrl.sv ====
`timescale 1ns/1ps

// fetch sequencer
// streams sequential insts, parks after a control-flow inst
// until execute strobes pc_update
module fetch_ctrl (
	input  logic  clk,
	input  logic  rst,
	input  logic  redirect,   // current inst is control flow
	input  logic  ready,      // decode can accept
	input  logic  pc_update,  // dnpc valid this cycle
	output logic  valid,      // pc/inst offered to decode
	output logic  pc_hold,
	output logic  pc_take
);

	typedef enum logic {
		idle,
		wait_target   // control-flow inst handed over, target pending
	} fetch_state_t;

	fetch_state_t state;
	fetch_state_t state_next;

	// ************************************************************************
	// state register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			state <= state_next;
		end
	end

	// ************************************************************************
	// next state and outputs
	// ************************************************************************

	always_comb begin
		state_next = state;
		valid      = 1'b0;
		pc_hold    = 1'b1;
		pc_take    = 1'b0;
		case (state)
			idle: begin
				valid   = 1'b1;                 // decode qualifies with ready
				pc_hold = redirect | ~ready;    // stall on flow inst or backpressure
				if (redirect && ready) begin
					state_next = wait_target;   // flow inst transferred
				end
			end
			wait_target: begin
				// nothing offered while the target is unknown
				pc_take = pc_update;
				pc_hold = ~pc_update;
				if (pc_update) begin
					state_next = idle;
				end
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	// an unknown strobe while parked would load an unknown target
	a_update_known: assert property (
		@(posedge clk) disable iff (rst)
		(state == wait_target) |-> !$isunknown(pc_update)
	) else $error("fetch_ctrl: pc_update unknown in wait_target");

endmodule

// ==== hdl/ifu_top.sv ====
`timescale 1ns/1ps

// instruction fetch unit
// ring of pc -> memory -> classifier -> sequencer -> pc
module ifu_top (
	input  logic                  clk,
	input  logic                  rst,

	// decode side
	input  logic                  ready,
	output logic                  valid,
	output fetch_pkg::addr_t      pc,
	output fetch_pkg::inst_t      inst,

	// execute side
	input  fetch_pkg::addr_t      dnpc,
	input  logic                  pc_update,

	// program fill
	input  logic                  load_en,
	input  fetch_pkg::mem_idx_t   load_addr,
	input  fetch_pkg::mem_word_t  load_data
);

	logic redirect;   // inst at pc is control flow
	logic pc_hold;
	logic pc_take;

	// ************************************************************************
	// fetch loop
	// ************************************************************************

	fetch_pc fetch_pc_inst (
		.clk      (clk),
		.rst      (rst),
		.dnpc     (dnpc),
		.pc_hold  (pc_hold),
		.pc_take  (pc_take),
		.pc       (pc)
	);

	inst_mem inst_mem_inst (
		.clk        (clk),
		.pc         (pc),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.inst       (inst)
	);

	flow_decode flow_decode_inst (
		.inst      (inst),
		.redirect  (redirect)
	);

	fetch_ctrl fetch_ctrl_inst (
		.clk        (clk),
		.rst        (rst),
		.redirect   (redirect),
		.ready      (ready),
		.pc_update  (pc_update),
		.valid      (valid),
		.pc_hold    (pc_hold),
		.pc_take    (pc_take)
	);

endmodule

// ==== sim/ifu_model.svh ====
`ifndef IFU_MODEL_SVH
`define IFU_MODEL_SVH

	// ************************************************************************
	// reference model of the fetch unit
	// ************************************************************************

	fetch_pkg::mem_word_t m_mem [fetch_pkg::MEM_WORDS];  // mirror of loaded program
	fetch_pkg::addr_t     m_pc;                          // expected pc
	logic                 m_wait;                        // target still pending

	// rv64 control-flow encodings
	function automatic logic flow_inst(input fetch_pkg::inst_t i);
		logic       hit;
		logic [2:0] f3;
		f3 = i[14:12];
		case (i[6:0])
			7'b1101111: hit = 1'b1;                           // jal
			7'b1100111: hit = (f3 == 3'b000);                 // jalr
			7'b1100011: hit = (f3 != 3'b010) && (f3 != 3'b011);  // branches
			default:    hit = (i == 32'h0000_0073) || (i == 32'h3020_0073);
		endcase
		return hit;
	endfunction

	// row from pc[10:3], half from pc[2]
	function automatic fetch_pkg::inst_t expected_inst(input fetch_pkg::addr_t a);
		fetch_pkg::mem_word_t w;
		w = m_mem[a[10:3]];
		return a[2] ? w[63:32] : w[31:0];
	endfunction

	function automatic logic expected_valid();
		return !m_wait;   // offered in idle only
	endfunction

	// one clock edge with the given inputs
	function automatic void advance_model(input logic rdy, input logic upd,
	                                      input fetch_pkg::addr_t tgt);
		if (m_wait) begin
			if (upd) begin
				m_pc   = tgt;
				m_wait = 1'b0;
			end
		end else if (rdy) begin
			if (flow_inst(expected_inst(m_pc))) begin
				m_wait = 1'b1;          // pc parks on the flow inst
			end else begin
				m_pc = m_pc + 64'd4;
			end
		end
	endfunction

`endif

// ==== sim/tb_ifu_top.sv ====
`timescale 1ns/1ps

module tb_ifu_top;

	logic                  clk;
	logic                  rst;
	logic                  ready;
	logic                  valid;
	fetch_pkg::addr_t      pc;
	fetch_pkg::inst_t      inst;
	fetch_pkg::addr_t      dnpc;
	logic                  pc_update;
	logic                  load_en;
	fetch_pkg::mem_idx_t   load_addr;
	fetch_pkg::mem_word_t  load_data;

	int   checks;
	int   errors;
	int   tests;
	int   mark_checks;   // counts when the current test began
	int   mark_errors;
	logic timed_out;

	`include "ifu_model.svh"

	ifu_top ifu_top_inst (
		.clk        (clk),
		.rst        (rst),
		.ready      (ready),
		.valid      (valid),
		.pc         (pc),
		.inst       (inst),
		.dnpc       (dnpc),
		.pc_update  (pc_update),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_data  (load_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ************************************************************************
	// stimulus helpers
	// ************************************************************************

	function automatic logic chance(input int pct);
		return $urandom_range(99) < pct;
	endfunction

	// aligned target inside the 2 KiB image
	function automatic fetch_pkg::addr_t pick_target();
		return fetch_pkg::RESET_PC + (fetch_pkg::addr_t'($urandom_range(511)) << 2);
	endfunction

	function automatic fetch_pkg::inst_t random_inst();
		fetch_pkg::inst_t r;
		logic [2:0]       f3;
		r  = $urandom();
		f3 = 3'($urandom_range(5));
		if (f3 > 3'd1) begin
			f3 = f3 + 3'd2;   // skip reserved 010/011
		end
		if ($urandom_range(7) != 0) begin
			return r;         // plain word, may still decode as flow
		end
		case ($urandom_range(6))
			0:       r[6:0] = 7'b1101111;                          // jal
			1:       r = {r[31:15], 3'b000, r[11:7], 7'b1100111};  // jalr
			2:       r = {r[31:15], f3, r[11:7], 7'b1100011};      // any branch
			3:       r = 32'h0000_0073;                            // ecall
			4:       r = 32'h3020_0073;                            // mret
			5:       r = {r[31:15], 3'b010, r[11:7], 7'b1100011};  // near miss
			default: r = 32'h0000_0073 ^ (32'h1 << $urandom_range(31));
		endcase
		return r;
	endfunction

	task automatic check_outputs();
		checks += 3;
		assert (valid === expected_valid()) else begin
			$display("error: valid got %h expected %h", valid, expected_valid());
			errors++;
		end
		assert (pc === m_pc) else begin
			$display("error: pc got %h expected %h", pc, m_pc);
			errors++;
		end
		assert (inst === expected_inst(m_pc)) else begin
			$display("error: inst got %h expected %h", inst, expected_inst(m_pc));
			errors++;
		end
	endtask

	// drive on the rising edge, check at the falling edge, then step the model
	task automatic drive_and_check(input logic rdy, input logic upd,
	                               input fetch_pkg::addr_t tgt);
		@(posedge clk);
		ready     <= rdy;
		pc_update <= upd;
		dnpc      <= tgt;
		@(negedge clk);
		check_outputs();
		advance_model(rdy, upd, tgt);
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name,
		         checks - mark_checks, errors - mark_errors);
		tests++;
		mark_checks = checks;
		mark_errors = errors;
	endtask

	task automatic stream_random(input int n, input int ready_pct, input int upd_pct);
		int wait_run;   // cycles spent in the current wait
		wait_run = 0;
		for (int i = 0; i < n && !timed_out; i++) begin
			drive_and_check(chance(ready_pct), chance(upd_pct), pick_target());
			wait_run = m_wait ? wait_run + 1 : 0;
			if (wait_run >= 50) begin
				$display("timeout: fetch waited 50 cycles for a redirect");
				timed_out = 1'b1;
			end
		end
	endtask

	// ************************************************************************
	// control-flow rounds, each wait bounded
	// ************************************************************************

	task automatic chase_redirects(input int rounds);
		fetch_pkg::addr_t held;
		fetch_pkg::addr_t target;
		fetch_pkg::addr_t tgt;
		logic             upd;
		int               n;
		for (int k = 0; k < rounds && !timed_out; k++) begin
			n = 0;
			while (!m_wait && n < 400) begin   // stream until a flow inst transfers
				drive_and_check(1'b1, 1'b0, pick_target());
				n++;
			end
			if (!m_wait) begin
				$display("timeout: no control-flow instruction within 400 cycles");
				timed_out = 1'b1;
			end else begin
				held   = m_pc;
				target = held;
				n      = 0;
				while (m_wait && n < 50) begin
					upd = chance(25);
					tgt = pick_target();
					drive_and_check(chance(75), upd, tgt);
					if (upd) begin
						target = tgt;
					end
					checks += 2;
					assert (pc === held) else begin
						$display("error: pc got %h expected %h in wait", pc, held);
						errors++;
					end
					assert (valid === 1'b0) else begin
						$display("error: valid got %h expected %h in wait", valid, 1'b0);
						errors++;
					end
					n++;
				end
				if (m_wait) begin
					$display("timeout: fetch waited 50 cycles for pc_update");
					timed_out = 1'b1;
				end else begin
					drive_and_check(1'b0, 1'b0, pick_target());
					checks += 2;
					assert (pc === target) else begin
						$display("error: pc got %h expected %h after redirect", pc, target);
						errors++;
					end
					assert (valid === 1'b1) else begin
						$display("error: valid got %h expected %h after redirect",
						         valid, 1'b1);
						errors++;
					end
				end
			end
		end
	endtask

	// ************************************************************************
	// main sequence
	// ************************************************************************

	initial begin
		fetch_pkg::mem_word_t w;
		void'($urandom(83801));
		checks      = 0;
		errors      = 0;
		tests       = 0;
		mark_checks = 0;
		mark_errors = 0;
		timed_out   = 1'b0;
		rst         = 1'b1;
		ready       = 1'b0;   // fetch stalled through the fill
		pc_update   = 1'b0;
		dnpc        = fetch_pkg::RESET_PC;
		load_en     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		m_pc        = fetch_pkg::RESET_PC;
		m_wait      = 1'b0;

		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checks += 2;
		assert (pc === fetch_pkg::RESET_PC) else begin
			$display("error: pc got %h expected %h", pc, fetch_pkg::RESET_PC);
			errors++;
		end
		assert (valid === 1'b1) else begin
			$display("error: valid got %h expected %h", valid, 1'b1);
			errors++;
		end
		end_test("reset");

		for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
			@(posedge clk);
			w = {random_inst(), random_inst()};
			load_en   <= 1'b1;
			load_addr <= fetch_pkg::mem_idx_t'(i);
			load_data <= w;
			m_mem[fetch_pkg::mem_idx_t'(i)] = w;
		end
		@(posedge clk);
		load_en <= 1'b0;
		drive_and_check(1'b0, 1'b0, pick_target());   // pc still parked at reset
		end_test("program_load");

		stream_random(200, 100, 25);
		end_test("sequential");
		stream_random(300, 40, 25);
		end_test("backpressure");
		chase_redirects(20);
		end_test("control_flow");
		stream_random(200, 75, 100);   // strobes in idle too
		end_test("idle_strobes");
		stream_random(600, 75, 25);
		end_test("random_mix");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+sim
hdl/fetch_pkg.sv
hdl/fetch_pc.sv
hdl/inst_mem.sv
hdl/flow_decode.sv
hdl/fetch_ctrl.sv
hdl/ifu_top.sv
sim/tb_ifu_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_ifu_top \
	-Mdir obj_dir -o tb_ifu_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_ifu_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the log only
if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
exit 1
